// ==== list.f ====
hdl/cam_bist_pkg.sv
hdl/bcam_array.sv
hdl/cam_bist_seq.sv
hdl/cam_bist_outhandler.sv
hdl/cam_bist_regs.sv
hdl/cam_bist_top.sv
verif/cam_bist_assert.sv
verif/cam_bist_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CAM BIST testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cam_bist_tb -f list.f -o Vcam_bist_tb

out=$(./obj_dir/Vcam_bist_tb 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Simulation finished: PASS"

// ==== verif/cam_bist_tb.sv ====
// CAM BIST testbench
// Directed APB tests checked against a march reference model
`timescale 1ns/100ps
`default_nettype none

module cam_bist_tb;

  localparam int entries = cam_bist_pkg::cam_entries;
  localparam int clk_half = 4;
  // Six tests with under 100 APB accesses each plus three runs of about 90 cycles,
  // well below 5000 cycles, which gives 40 us at 8 ns
  localparam int watchdog_cycles = 5000;

  logic        bist_clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int          err_count;
  int          test_errs_start;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lcg_state;

  // Model of the array contents
  logic [7:0]  image [entries];

  // Predicted BIST result
  logic        exp_fail;
  logic [3:0]  exp_fail_addr;
  logic [7:0]  exp_fail_count;

  cam_bist_top cam_bist_top_i (
    .bist_clk (bist_clk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  initial begin
    bist_clk = 1'b0;
    forever #clk_half bist_clk = ~bist_clk;
  end

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper bits of the LCG are the better mixed ones
  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = rand_next();
    return r[23:16];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    err_count++;
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    err_count++;
  endtask

  task automatic begin_test();
    test_errs_start = err_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == test_errs_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - test_errs_start);
    end
  endtask

  // ====================
  // APB driver
  // ====================
  // Called just after a rising edge, returns just after one
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge bist_clk);
    #1;
    penable = 1'b1;
    // Mid-cycle sample of the access phase
    @(negedge bist_clk);
    if (pready !== 1'b1) report_error("pready low in a write access phase");
    if (pslverr !== exp_err) report_mismatch("pslverr", {31'b0, pslverr}, {31'b0, exp_err});
    @(posedge bist_clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge bist_clk);
    #1;
    penable = 1'b1;
    @(negedge bist_clk);
    data = prdata;
    if (pready !== 1'b1) report_error("pready low in a read access phase");
    if (pslverr !== exp_err) report_mismatch("pslverr", {31'b0, pslverr}, {31'b0, exp_err});
    @(posedge bist_clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // ====================
  // Functional access
  // ====================
  task automatic send_cmd(input cam_bist_pkg::cam_op_e op, input logic [3:0] addr,
                          input logic [7:0] data);
    apb_write(cam_bist_pkg::reg_func_cmd, {16'h0, data, addr, 2'b00, op}, 1'b0);
  endtask

  task automatic wait_func_done();
    logic [31:0] st;
    int polls;
    st = '0;
    polls = 0;
    while ((st[3] !== 1'b1) && (polls < 50)) begin
      apb_read(cam_bist_pkg::reg_status, st, 1'b0);
      polls++;
    end
    if (st[3] !== 1'b1) report_error("functional access never completed");
  endtask

  task automatic func_write(input logic [3:0] addr, input logic [7:0] data);
    send_cmd(cam_bist_pkg::op_write, addr, data);
    image[addr] = data;
  endtask

  task automatic func_read(input logic [3:0] addr, output logic [31:0] data);
    send_cmd(cam_bist_pkg::op_read, addr, 8'h00);
    wait_func_done();
    apb_read(cam_bist_pkg::reg_func_rdata, data, 1'b0);
  endtask

  task automatic func_search(input logic [7:0] key, output logic [31:0] match);
    send_cmd(cam_bist_pkg::op_search, 4'h0, key);
    wait_func_done();
    apb_read(cam_bist_pkg::reg_func_match, match, 1'b0);
  endtask

  // ====================
  // Reference model
  // ====================
  function automatic logic [15:0] match_of(input logic [7:0] key);
    logic [15:0] hits;
    for (int i = 0; i < entries; i++) begin
      hits[i] = (image[i] == key);
    end
    return hits;
  endfunction

  // One search of the march, logged like the sequencer does
  task automatic log_search(input logic [15:0] actual, input logic [15:0] expected,
                            input logic [3:0] addr);
    if (actual != expected) begin
      if (!exp_fail) begin
        exp_fail_addr = addr;
      end
      exp_fail = 1'b1;
      if (exp_fail_count != 8'hFF) begin
        exp_fail_count = exp_fail_count + 8'd1;
      end
    end
  endtask

  task automatic predict_march(input logic [7:0] pat, input logic no_write);
    logic [15:0] one_hot;
    exp_fail = 1'b0;
    exp_fail_addr = 4'h0;
    exp_fail_count = 8'h00;
    if (!no_write) begin
      for (int i = 0; i < entries; i++) begin
        image[i] = pat;
      end
    end
    // Global searches carry address 0
    log_search(match_of(pat), 16'hFFFF, 4'h0);
    log_search(match_of(~pat), 16'h0000, 4'h0);
    for (int a = 0; a < entries; a++) begin
      one_hot = 16'h1 << a;
      image[a] = ~pat;
      log_search(match_of(~pat), one_hot, 4'(a));
      log_search(match_of(pat), ~one_hot, 4'(a));
      image[a] = pat;
    end
  endtask

  // ====================
  // BIST control
  // ====================
  task automatic start_bist(input logic [7:0] pat, input logic no_write);
    apb_write(cam_bist_pkg::reg_pattern, {24'h0, pat}, 1'b0);
    apb_write(cam_bist_pkg::reg_ctrl, {30'b0, no_write, 1'b1}, 1'b0);
  endtask

  task automatic wait_bist_done();
    logic [31:0] st;
    int polls;
    st = '0;
    polls = 0;
    while ((st[1] !== 1'b1) && (polls < 100)) begin
      apb_read(cam_bist_pkg::reg_status, st, 1'b0);
      polls++;
    end
    if (st[1] !== 1'b1) report_error("BIST run did not reach done");
  endtask

  task automatic check_bist_result();
    logic [31:0] rd;
    apb_read(cam_bist_pkg::reg_status, rd, 1'b0);
    if (rd[0] !== 1'b0) report_error("busy still set after done");
    if (rd[2] !== exp_fail) report_mismatch("status.fail", {31'b0, rd[2]}, {31'b0, exp_fail});
    apb_read(cam_bist_pkg::reg_fail_addr, rd, 1'b0);
    if (rd !== {28'h0, exp_fail_addr}) begin
      report_mismatch("fail_addr", rd, {28'h0, exp_fail_addr});
    end
    apb_read(cam_bist_pkg::reg_fail_count, rd, 1'b0);
    if (rd !== {24'h0, exp_fail_count}) begin
      report_mismatch("fail_count", rd, {24'h0, exp_fail_count});
    end
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_write_read();
    logic [7:0] r;
    logic [7:0] data;
    logic [31:0] rd;
    begin_test();
    for (int n = 0; n < 6; n++) begin
      r = rand_byte();
      data = rand_byte();
      func_write(r[3:0], data);
      func_read(r[3:0], rd);
      if (rd !== {24'h0, data}) report_mismatch("func_rdata", rd, {24'h0, data});
    end
    end_test("functional write and read");
  endtask

  task automatic test_search();
    logic [7:0] key;
    logic [7:0] r;
    logic [15:0] exp_match;
    logic [31:0] rd;
    begin_test();
    key = rand_byte();
    for (int i = 0; i < entries; i++) begin
      r = rand_byte();
      // About half of the entries hold the key
      func_write(4'(i), r[0] ? key : rand_byte());
    end
    exp_match = match_of(key);
    func_search(key, rd);
    if (rd !== {16'h0, exp_match}) report_mismatch("func_match", rd, {16'h0, exp_match});
    exp_match = match_of(~key);
    func_search(~key, rd);
    if (rd !== {16'h0, exp_match}) report_mismatch("func_match", rd, {16'h0, exp_match});
    end_test("functional search");
  endtask

  task automatic test_bist_clean();
    logic [7:0] pat;
    begin_test();
    pat = rand_byte();
    predict_march(pat, 1'b0);
    start_bist(pat, 1'b0);
    wait_bist_done();
    check_bist_result();
    end_test("clean BIST run");
  endtask

  task automatic test_retention();
    logic [7:0] pat;
    logic [7:0] r;
    logic [3:0] k;
    begin_test();
    pat = rand_byte();
    r = rand_byte();
    k = r[3:0];
    for (int i = 0; i < entries; i++) begin
      func_write(4'(i), pat);
    end
    // Low bit set and top bit clear, so neither P nor its inverse
    func_write(k, pat ^ {1'b0, r[6:1], 1'b1});
    predict_march(pat, 1'b1);
    start_bist(pat, 1'b1);
    wait_bist_done();
    check_bist_result();
    end_test("retention with no_write");
  endtask

  task automatic test_bus_errors();
    logic [7:0] pat;
    logic [31:0] rd;
    begin_test();
    apb_read(8'h20, rd, 1'b1);
    pat = rand_byte();
    predict_march(pat, 1'b0);
    start_bist(pat, 1'b0);
    // Both writes refused while the run is going
    apb_write(cam_bist_pkg::reg_func_cmd, {16'h0, ~pat, 4'h3, 2'b00, cam_bist_pkg::op_write},
              1'b1);
    apb_write(cam_bist_pkg::reg_ctrl, 32'h3, 1'b1);
    wait_bist_done();
    check_bist_result();
    // Refused control write left no_write as the run started it
    apb_read(cam_bist_pkg::reg_ctrl, rd, 1'b0);
    if (rd[1] !== 1'b0) report_mismatch("ctrl.no_write", {31'b0, rd[1]}, 32'h0);
    end_test("bus errors");
  endtask

  task automatic test_readback();
    logic [31:0] rd;
    begin_test();
    for (int i = 0; i < entries; i++) begin
      func_read(4'(i), rd);
      if (rd !== {24'h0, image[i]}) report_mismatch("func_rdata", rd, {24'h0, image[i]});
    end
    end_test("readback after BIST");
  endtask

  // ====================
  // Watchdog
  // ====================
  initial begin
    repeat (watchdog_cycles) @(posedge bist_clk);
    $display("Watchdog expired after %0d cycles, tests did not complete", watchdog_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    lcg_state = 32'd39349;
    err_count = 0;
    test_errs_start = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 8'h00;
    pwdata = 32'h0;
    repeat (8) @(posedge bist_clk);
    #1;
    rst_n = 1'b1;
    test_write_read();
    test_search();
    test_bist_clean();
    test_retention();
    test_bus_errors();
    test_readback();
    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/cam_bist_assert.sv ====
// CAM BIST bound checks
// APB error response timing and BIST status consistency
`timescale 1ns/100ps
`default_nettype none

module cam_bist_assert (
  input logic                       bist_clk,
  input logic                       rst_n,
  input logic                       psel,
  input logic                       penable,
  input logic                       pslverr,
  input logic                       cm_mode,
  input cam_bist_pkg::bist_status_t status,
  input cam_bist_pkg::bist_cfg_t    cfg,
  input cam_bist_pkg::cam_req_t     func_req
);

  // Error response only in the access phase and never with a start or a request
  a_slverr_access: assert property (@(posedge bist_clk) disable iff (!rst_n)
    pslverr |-> (psel && penable && !cfg.start &&
                 (func_req.op == cam_bist_pkg::op_nop)))
    else $error("pslverr outside an APB access phase or with a side effect");

  // Compare mode belongs to a running march
  a_cm_busy: assert property (@(posedge bist_clk) disable iff (!rst_n)
    cm_mode |-> status.busy)
    else $error("cm_mode high while the sequencer is idle");

  // done and busy exclude each other
  a_done_busy: assert property (@(posedge bist_clk) disable iff (!rst_n)
    !(status.done && status.busy))
    else $error("done and busy set together");

endmodule

bind cam_bist_top cam_bist_assert cam_bist_assert_i (
  .bist_clk (bist_clk),
  .rst_n    (rst_n),
  .psel     (psel),
  .penable  (penable),
  .pslverr  (pslverr),
  .cm_mode  (cm_mode),
  .status   (status),
  .cfg      (cfg),
  .func_req (func_req)
);

`default_nettype wire

// ==== hdl/cam_bist_top.sv ====
// CAM macro with BIST
// Array, march sequencer, output handler and APB registers
`timescale 1ns/100ps
`default_nettype none

module cam_bist_top (
  input  logic        bist_clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  cam_bist_pkg::cam_req_t                 cam_req;
  cam_bist_pkg::cam_req_t                 func_req;
  cam_bist_pkg::cam_rsp_t                 cam_rsp;
  cam_bist_pkg::bist_cfg_t                cfg;
  cam_bist_pkg::bist_status_t             status;
  cam_bist_pkg::match_sel_e               match_sel;
  logic                                   cm_mode;
  logic [cam_bist_pkg::cam_dwidth-1:0]    rd_data_out;

  bcam_array bcam_array_i (
    .bist_clk (bist_clk),
    .rst_n    (rst_n),
    .req      (cam_req),
    .rsp      (cam_rsp)
  );

  // Aligned compare address stays inside for fail logging
  cam_bist_seq cam_bist_seq_i (
    .bist_clk    (bist_clk),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .func_req    (func_req),
    .rd_data_out (rd_data_out),
    .cam_req     (cam_req),
    .cm_mode     (cm_mode),
    .match_sel   (match_sel),
    .cmp_addr    (),
    .status      (status)
  );

  // Fed with the issued address, delayed inside to meet the response
  cam_bist_outhandler #(
    .entries (cam_bist_pkg::cam_entries),
    .dwidth  (cam_bist_pkg::cam_dwidth)
  ) cam_bist_outhandler_i (
    .bist_clk     (bist_clk),
    .cm_mode      (cm_mode),
    .match_sel    (match_sel),
    .addr         (cam_req.addr),
    .match_lines  (cam_rsp.match),
    .rdata        (cam_rsp.rdata),
    .rd_data_out  (rd_data_out),
    .cm_match_ref ()
  );

  cam_bist_regs cam_bist_regs_i (
    .bist_clk    (bist_clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .status      (status),
    .rsp         (cam_rsp),
    .rd_data_out (rd_data_out),
    .cfg         (cfg),
    .func_req    (func_req)
  );

endmodule

`default_nettype wire

// ==== hdl/cam_bist_regs.sv ====
// CAM BIST APB register block
// BIST control and status, plus functional array access
`timescale 1ns/100ps
`default_nettype none

module cam_bist_regs (
  input  logic                                  bist_clk,
  input  logic                                  rst_n,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [7:0]                            paddr,
  input  logic [31:0]                           pwdata,
  output logic [31:0]                           prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  input  cam_bist_pkg::bist_status_t            status,
  input  cam_bist_pkg::cam_rsp_t                rsp,
  input  logic [cam_bist_pkg::cam_dwidth-1:0]   rd_data_out,
  output cam_bist_pkg::bist_cfg_t               cfg,
  output cam_bist_pkg::cam_req_t                func_req
);

  localparam int entries = cam_bist_pkg::cam_entries;
  localparam int dwidth  = cam_bist_pkg::cam_dwidth;
  localparam int awidth  = cam_bist_pkg::cam_awidth;

  logic               access;
  logic               mapped;
  logic               locked;
  logic               wr;
  logic               wr_ctrl;
  logic               wr_cmd;
  logic               no_write_q;
  logic [dwidth-1:0]  pattern_q;
  logic               func_done_q;
  logic [dwidth-1:0]  func_rdata_q;
  logic [entries-1:0] func_match_q;

  // ====================
  // APB decode
  // ====================
  assign access = psel & penable;
  assign pready = 1'b1;

  // Control writes are refused during a run
  assign locked = pwrite & status.busy &
                  ((paddr == cam_bist_pkg::reg_ctrl) || (paddr == cam_bist_pkg::reg_func_cmd));
  assign pslverr = access & (~mapped | locked);

  assign wr = access & pwrite & mapped & ~locked;
  assign wr_ctrl = wr & (paddr == cam_bist_pkg::reg_ctrl);
  assign wr_cmd = wr & (paddr == cam_bist_pkg::reg_func_cmd);

  // Read mux, also flags unmapped offsets
  always_comb begin
    prdata = '0;
    mapped = 1'b1;
    case (paddr)
      cam_bist_pkg::reg_ctrl:       prdata[1] = no_write_q;
      cam_bist_pkg::reg_pattern:    prdata[dwidth-1:0] = pattern_q;
      cam_bist_pkg::reg_status:     prdata[3:0] = {func_done_q, status.fail, status.done,
                                                   status.busy};
      cam_bist_pkg::reg_fail_addr:  prdata[awidth-1:0] = status.fail_addr;
      cam_bist_pkg::reg_fail_count: prdata[7:0] = status.fail_count;
      cam_bist_pkg::reg_func_cmd:   prdata = '0;
      cam_bist_pkg::reg_func_rdata: prdata[dwidth-1:0] = func_rdata_q;
      cam_bist_pkg::reg_func_match: prdata[entries-1:0] = func_match_q;
      default:                      mapped = 1'b0;
    endcase
  end

  // ====================
  // Control outputs
  // ====================
  // Start pulses in the access cycle, no_write seen with it
  assign cfg = {wr_ctrl & pwdata[0], wr_ctrl ? pwdata[1] : no_write_q, pattern_q};

  // Functional request lives for the access cycle only
  always_comb begin
    func_req.op = cam_bist_pkg::op_nop;
    func_req.addr = pwdata[4 +: awidth];
    func_req.data = pwdata[8 +: dwidth];
    if (wr_cmd) begin
      func_req.op = cam_bist_pkg::cam_op_e'(pwdata[1:0]);
    end
  end

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      no_write_q <= 1'b0;
      pattern_q <= '0;
      func_done_q <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        no_write_q <= pwdata[1];
      end
      if (wr && (paddr == cam_bist_pkg::reg_pattern)) begin
        pattern_q <= pwdata[dwidth-1:0];
      end
      // New command clears the previous completion
      if (wr_cmd) begin
        func_done_q <= 1'b0;
      end else if (rsp.valid && !status.busy) begin
        func_done_q <= 1'b1;
      end
    end
  end

  // Functional result capture
  always_ff @(posedge bist_clk) begin
    if (rsp.valid && !status.busy) begin
      func_rdata_q <= rd_data_out;
      func_match_q <= rsp.match;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cam_bist_outhandler.sv ====
// CAM BIST output handler
// Expected match build, compare, compaction onto the read bus
`timescale 1ns/100ps
`default_nettype none

module cam_bist_outhandler #(
  parameter int entries = 16,
  parameter int dwidth  = 8
) (
  input  logic                         bist_clk,
  input  logic                         cm_mode,
  input  cam_bist_pkg::match_sel_e     match_sel,
  input  logic [$clog2(entries)-1:0]   addr,
  input  logic [entries-1:0]           match_lines,
  input  logic [dwidth-1:0]            rdata,
  output logic [dwidth-1:0]            rd_data_out,
  output logic [entries-1:0]           cm_match_ref
);

  localparam int awidth = $clog2(entries);

  logic [awidth-1:0]  addr_1h;
  logic [awidth-1:0]  addr_2h;
  logic [entries-1:0] one_hot;
  logic [entries-1:0] miscmp;
  logic [dwidth-1:0]  cmp_word;

  // ====================
  // Expected match vector
  // ====================
  // Request address delayed by the array latency
  always_ff @(posedge bist_clk) begin
    addr_1h <= addr;
    addr_2h <= addr_1h;
  end

  assign one_hot = {{(entries-1){1'b0}}, 1'b1} << addr_2h;

  always_comb begin
    unique case (match_sel)
      cam_bist_pkg::sel_all_match:       cm_match_ref = '1;
      cam_bist_pkg::sel_single_match:    cm_match_ref = one_hot;
      cam_bist_pkg::sel_single_mismatch: cm_match_ref = ~one_hot;
      cam_bist_pkg::sel_all_mismatch:    cm_match_ref = '0;
      default:                           cm_match_ref = '0;
    endcase
  end

  // A set bit marks an entry that disagrees with the expectation
  assign miscmp = cm_match_ref ^ match_lines;

  // ====================
  // Compactor
  // ====================
  generate
    if (dwidth < entries) begin : g_compact
      localparam int groups = entries / dwidth;
      localparam int rem = entries % dwidth;
      logic [dwidth-1:0] folded;

      // OR together bits that share index mod dwidth
      always_comb begin
        folded = '0;
        for (int g = 0; g < groups; g++) begin
          folded = folded | miscmp[g*dwidth +: dwidth];
        end
      end

      if (rem != 0) begin : g_rem
        // Leftover top entries land in the upper bits
        assign cmp_word = folded | {miscmp[entries-1 -: rem], {(dwidth-rem){1'b0}}};
      end else begin : g_even
        assign cmp_word = folded;
      end
    end else if (dwidth == entries) begin : g_equal
      assign cmp_word = miscmp;
    end else begin : g_expand
      // Wide bus, result sits in the upper bits
      assign cmp_word = {miscmp, {(dwidth-entries){1'b0}}};
    end
  endgenerate

  // Compare result replaces read data only in compare mode
  assign rd_data_out = cm_mode ? cmp_word : rdata;

endmodule

`default_nettype wire

// ==== hdl/cam_bist_seq.sv ====
// CAM BIST march sequencer
// Arbitrates functional and BIST requests and logs failures
`timescale 1ns/100ps
`default_nettype none

module cam_bist_seq (
  input  logic                                    bist_clk,
  input  logic                                    rst_n,
  input  cam_bist_pkg::bist_cfg_t                 cfg,
  input  cam_bist_pkg::cam_req_t                  func_req,
  input  logic [cam_bist_pkg::cam_dwidth-1:0]     rd_data_out,
  output cam_bist_pkg::cam_req_t                  cam_req,
  output logic                                    cm_mode,
  output cam_bist_pkg::match_sel_e                match_sel,
  output logic [cam_bist_pkg::cam_awidth-1:0]     cmp_addr,
  output cam_bist_pkg::bist_status_t              status
);

  localparam int dwidth = cam_bist_pkg::cam_dwidth;
  localparam int awidth = cam_bist_pkg::cam_awidth;

  cam_bist_pkg::bist_state_e state;
  logic [awidth-1:0]         cnt;
  logic [1:0]                sub;
  logic [dwidth-1:0]         pat;
  logic                      start_ok;

  // Search issued this cycle, with its expected result
  logic                      srch_vld;
  cam_bist_pkg::match_sel_e  srch_sel;

  // First compare stage
  logic                      cv_1h;
  cam_bist_pkg::match_sel_e  sel_1h;
  logic [awidth-1:0]         addr_1h;

  // Result log
  logic                      done_q;
  logic                      fail_q;
  logic [awidth-1:0]         fail_addr_q;
  logic [7:0]                fail_cnt_q;

  assign start_ok = (state == cam_bist_pkg::st_idle) && cfg.start;

  // ====================
  // March FSM
  // ====================
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      state <= cam_bist_pkg::st_idle;
      cnt <= '0;
      sub <= '0;
    end else begin
      case (state)
        cam_bist_pkg::st_idle: begin
          if (cfg.start) begin
            cnt <= '0;
            sub <= '0;
            // Retention mode goes straight to the checks
            state <= cfg.no_write ? cam_bist_pkg::st_srch_all : cam_bist_pkg::st_fill;
          end
        end
        cam_bist_pkg::st_fill: begin
          cnt <= cnt + 1'b1;
          if (cnt == '1) begin
            state <= cam_bist_pkg::st_srch_all;
          end
        end
        cam_bist_pkg::st_srch_all:  state <= cam_bist_pkg::st_srch_none;
        cam_bist_pkg::st_srch_none: state <= cam_bist_pkg::st_walk;
        cam_bist_pkg::st_walk: begin
          // Four sub-steps per address
          sub <= sub + 1'b1;
          if (sub == 2'd3) begin
            cnt <= cnt + 1'b1;
            if (cnt == '1) begin
              state <= cam_bist_pkg::st_drain;
            end
          end
        end
        cam_bist_pkg::st_drain: begin
          // Two cycles to flush the last search
          sub <= sub + 1'b1;
          if (sub == 2'd1) begin
            sub <= '0;
            state <= cam_bist_pkg::st_idle;
          end
        end
        default: state <= cam_bist_pkg::st_idle;
      endcase
    end
  end

  // Pattern held for the whole run
  always_ff @(posedge bist_clk) begin
    if (start_ok) begin
      pat <= cfg.pattern;
    end
  end

  // ====================
  // Request generation
  // ====================
  always_comb begin
    cam_req = func_req;
    srch_vld = 1'b0;
    srch_sel = cam_bist_pkg::sel_all_match;
    // Functional traffic dropped while busy
    if (state != cam_bist_pkg::st_idle) begin
      cam_req.op = cam_bist_pkg::op_nop;
      cam_req.addr = cnt;
      cam_req.data = pat;
    end
    case (state)
      cam_bist_pkg::st_fill: cam_req.op = cam_bist_pkg::op_write;
      cam_bist_pkg::st_srch_all: begin
        cam_req.op = cam_bist_pkg::op_search;
        cam_req.addr = '0;
        srch_vld = 1'b1;
      end
      cam_bist_pkg::st_srch_none: begin
        cam_req.op = cam_bist_pkg::op_search;
        cam_req.addr = '0;
        cam_req.data = ~pat;
        srch_vld = 1'b1;
        srch_sel = cam_bist_pkg::sel_all_mismatch;
      end
      cam_bist_pkg::st_walk: begin
        case (sub)
          // Write inverse, find it alone, find the rest, restore
          2'd0: begin
            cam_req.op = cam_bist_pkg::op_write;
            cam_req.data = ~pat;
          end
          2'd1: begin
            cam_req.op = cam_bist_pkg::op_search;
            cam_req.data = ~pat;
            srch_vld = 1'b1;
            srch_sel = cam_bist_pkg::sel_single_match;
          end
          2'd2: begin
            cam_req.op = cam_bist_pkg::op_search;
            srch_vld = 1'b1;
            srch_sel = cam_bist_pkg::sel_single_mismatch;
          end
          default: cam_req.op = cam_bist_pkg::op_write;
        endcase
      end
      default: ;
    endcase
  end

  // ====================
  // Compare alignment
  // ====================
  // Two stages to meet the array response
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      cv_1h <= 1'b0;
      cm_mode <= 1'b0;
    end else begin
      cv_1h <= srch_vld;
      cm_mode <= cv_1h;
    end
  end

  always_ff @(posedge bist_clk) begin
    sel_1h <= srch_sel;
    addr_1h <= cam_req.addr;
    match_sel <= sel_1h;
    cmp_addr <= addr_1h;
  end

  // ====================
  // Fail logging
  // ====================
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
      fail_q <= 1'b0;
      fail_addr_q <= '0;
      fail_cnt_q <= '0;
    end else if (start_ok) begin
      done_q <= 1'b0;
      fail_q <= 1'b0;
      fail_addr_q <= '0;
      fail_cnt_q <= '0;
    end else begin
      if ((state == cam_bist_pkg::st_drain) && (sub == 2'd1)) begin
        done_q <= 1'b1;
      end
      // Any set bit of the compacted word is a miscompare
      if (cm_mode && (|rd_data_out)) begin
        if (!fail_q) begin
          fail_addr_q <= cmp_addr;
        end
        fail_q <= 1'b1;
        if (fail_cnt_q != 8'hFF) begin
          fail_cnt_q <= fail_cnt_q + 1'b1;
        end
      end
    end
  end

  assign status = {(state != cam_bist_pkg::st_idle), done_q, fail_q, fail_addr_q, fail_cnt_q};

endmodule

`default_nettype wire

// ==== hdl/bcam_array.sv ====
// Behavioral binary CAM, 16 x 8
// One request per cycle, read and search answer two cycles later
`timescale 1ns/100ps
`default_nettype none

module bcam_array (
  input  logic                   bist_clk,
  input  logic                   rst_n,
  input  cam_bist_pkg::cam_req_t req,
  output cam_bist_pkg::cam_rsp_t rsp
);

  localparam int entries = cam_bist_pkg::cam_entries;
  localparam int dwidth  = cam_bist_pkg::cam_dwidth;
  localparam int awidth  = cam_bist_pkg::cam_awidth;

  // Storage
  logic [dwidth-1:0]  mem [entries];

  // Input stage
  logic               s1_vld;
  logic               s1_search;
  logic [awidth-1:0]  s1_addr;
  logic [dwidth-1:0]  s1_key;

  // Compare result against current contents
  logic [entries-1:0] hit;

  // Output stage
  logic               rsp_vld;
  logic [entries-1:0] rsp_match;
  logic [dwidth-1:0]  rsp_rdata;

  // ====================
  // Write port
  // ====================
  // Entry updates on the request edge itself
  always_ff @(posedge bist_clk) begin
    if (req.op == cam_bist_pkg::op_write) begin
      mem[req.addr] <= req.data;
    end
  end

  // ====================
  // Read and search pipe
  // ====================
  // Only read and search produce a response
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
      rsp_vld <= 1'b0;
    end else begin
      s1_vld <= (req.op == cam_bist_pkg::op_read) || (req.op == cam_bist_pkg::op_search);
      rsp_vld <= s1_vld;
    end
  end

  always_ff @(posedge bist_clk) begin
    s1_search <= (req.op == cam_bist_pkg::op_search);
    s1_addr <= req.addr;
    s1_key <= req.data;
  end

  // Every entry compared in parallel with the key
  always_comb begin
    for (int i = 0; i < entries; i++) begin
      hit[i] = (mem[i] == s1_key);
    end
  end

  // Match lines stay quiet for a plain read
  always_ff @(posedge bist_clk) begin
    rsp_match <= s1_search ? hit : '0;
    rsp_rdata <= mem[s1_addr];
  end

  assign rsp = {rsp_vld, rsp_match, rsp_rdata};

endmodule

`default_nettype wire

// ==== hdl/cam_bist_pkg.sv ====
// CAM BIST shared definitions
// Array geometry, opcodes, FSM states, register map and bus structs
`default_nettype none

package cam_bist_pkg;

  // ====================
  // Array geometry
  // ====================
  localparam int cam_entries = 16;
  localparam int cam_dwidth  = 8;
  localparam int cam_awidth  = 4;

  // Request opcodes seen by the array
  typedef enum logic [1:0] {
    op_nop,
    op_write,
    op_read,
    op_search
  } cam_op_e;

  // Expected search outcome, same encoding as the match select pins
  typedef enum logic [1:0] {
    sel_all_match       = 2'd0,
    sel_single_match    = 2'd1,
    sel_single_mismatch = 2'd2,
    sel_all_mismatch    = 2'd3
  } match_sel_e;

  // March phases
  typedef enum logic [2:0] {
    st_idle,
    st_fill,
    st_srch_all,
    st_srch_none,
    st_walk,
    st_drain
  } bist_state_e;

  // APB register offsets
  typedef enum logic [7:0] {
    reg_ctrl       = 8'h00,
    reg_pattern    = 8'h04,
    reg_status     = 8'h08,
    reg_fail_addr  = 8'h0C,
    reg_fail_count = 8'h10,
    reg_func_cmd   = 8'h14,
    reg_func_rdata = 8'h18,
    reg_func_match = 8'h1C
  } reg_addr_e;

  // ====================
  // Bus structs
  // ====================
  typedef struct packed {
    cam_op_e                 op;
    logic [cam_awidth-1:0]   addr;
    logic [cam_dwidth-1:0]   data;
  } cam_req_t;

  typedef struct packed {
    logic                    valid;
    logic [cam_entries-1:0]  match;
    logic [cam_dwidth-1:0]   rdata;
  } cam_rsp_t;

  typedef struct packed {
    logic                    start;
    logic                    no_write;
    logic [cam_dwidth-1:0]   pattern;
  } bist_cfg_t;

  typedef struct packed {
    logic                    busy;
    logic                    done;
    logic                    fail;
    logic [cam_awidth-1:0]   fail_addr;
    logic [7:0]              fail_count;
  } bist_status_t;

endpackage

`default_nettype wire
